// ==== Makefile ====
TOP = pio_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f source/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
source/pio_pkg.sv
source/pio_clk_div.sv
source/pio_instr_mem.sv
source/pio_tx_fifo.sv
source/pio_sm.sv
source/pio_top.sv
verif/pio_chk.sv
verif/pio_tb.sv

// ==== source/pio_clk_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_clk_div (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          en,
  input  wire pio_pkg::div_t div,
  output logic               tick
);

  pio_pkg::div_t cnt; // Clocks left until next tick

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (!en) begin
      cnt  <= '0; // Restart on disable
      tick <= 1'b0;
    end else if (cnt == '0) begin
      tick <= 1'b1;
      cnt  <= (div > 16'd1) ? div - 16'd1 : '0; // 0 and 1 both tick every clock
    end else begin
      tick <= 1'b0;
      cnt  <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/pio_instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_instr_mem (
  input  wire logic            clk,
  input  wire logic            we,
  input  wire pio_pkg::pc_t    waddr,
  input  wire pio_pkg::instr_t wdata,
  input  wire pio_pkg::pc_t    raddr,
  output pio_pkg::instr_t      rdata
);

  pio_pkg::instr_t mem [pio_pkg::IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr]; // Fetch is combinational from the PC

endmodule

`default_nettype wire

// ==== source/pio_pkg.sv ====
`default_nettype none

package pio_pkg;

  typedef logic [31:0] word_t;
  typedef logic [15:0] instr_t;
  typedef logic [4:0]  pc_t;
  typedef logic [4:0]  pin_idx_t;
  typedef logic [15:0] div_t;

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int IMEM_DEPTH = 32;

  localparam logic [5:0] OSR_EMPTY = 6'd32; // All 32 bits shifted out

  typedef enum logic [2:0] {
    OP_JMP  = 3'd0,
    OP_WAIT = 3'd1,
    OP_IN   = 3'd2,
    OP_OUT  = 3'd3,
    OP_PULL = 3'd4,
    OP_MOV  = 3'd5,
    OP_IRQ  = 3'd6,
    OP_SET  = 3'd7
  } op_e;

  typedef struct packed {
    op_e        op;    // Bits 15:13
    logic [4:0] delay; // No side-set, whole field is delay
    logic [2:0] op1;
    logic [4:0] op2;
  } decoded_t;

  typedef struct packed {
    div_t       div;
    pc_t        wrap_bottom;
    pc_t        wrap_top;
    pin_idx_t   out_base;
    logic [5:0] out_count; // 0 to 32
    pin_idx_t   set_base;
    logic [2:0] set_count; // 0 to 5
    pin_idx_t   jmp_pin;
    pin_idx_t   gpio_sel;
  } sm_cfg_t;

endpackage

`default_nettype wire

// ==== source/pio_sm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_sm (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             en,
  input  wire logic             tick,
  input  wire pio_pkg::sm_cfg_t cfg,
  input  wire pio_pkg::instr_t  instr,
  input  wire pio_pkg::word_t   gpio_in,
  input  wire pio_pkg::word_t   fifo_data,
  input  wire logic             fifo_empty,
  output logic                  fifo_rd,
  output pio_pkg::pc_t          pc,
  output pio_pkg::word_t        pins_out,
  output pio_pkg::word_t        pin_dirs
);

  pio_pkg::decoded_t d;
  pio_pkg::word_t    x_q;
  pio_pkg::word_t    y_q;
  pio_pkg::word_t    osr;
  logic [5:0]        osr_cnt;   // Bits already shifted out
  logic [4:0]        delay_cnt;

  logic              active;
  logic              exec;
  logic              stall;
  logic              jump;
  logic              pull_pop;
  pio_pkg::pc_t      jump_tgt;
  pio_pkg::pc_t      pc_seq;
  pio_pkg::pc_t      pc_nxt;
  pio_pkg::word_t    x_nxt;
  pio_pkg::word_t    y_nxt;
  pio_pkg::word_t    osr_nxt;
  pio_pkg::word_t    pins_nxt;
  pio_pkg::word_t    dirs_nxt;
  logic [5:0]        osr_cnt_nxt;

  logic [5:0]        out_n;
  logic [6:0]        out_sum;
  pio_pkg::word_t    out_mask;
  pio_pkg::word_t    out_val;
  pio_pkg::word_t    osr_shr;

  // Write the low count bits of val to pins starting at base, wrapping mod 32
  function automatic pio_pkg::word_t merge_pins(input pio_pkg::word_t cur,
                                                input pio_pkg::word_t val,
                                                input pio_pkg::pin_idx_t base,
                                                input logic [5:0] count);
    pio_pkg::word_t   res;
    pio_pkg::pin_idx_t idx;
    res = cur;
    for (int i = 0; i < 32; i++) begin
      idx = base + pio_pkg::pin_idx_t'(i);
      if (i < count) begin
        res[idx] = val[i];
      end
    end
    return res;
  endfunction

  assign d      = pio_pkg::decoded_t'(instr);
  assign active = en && tick;

  assign out_n    = (d.op2 == 5'd0) ? 6'd32 : {1'b0, d.op2}; // 0 means 32
  assign out_mask = (out_n == 6'd32) ? '1 : ((32'd1 << out_n) - 32'd1);
  assign out_val  = osr & out_mask;
  assign osr_shr  = (out_n == 6'd32) ? '0 : (osr >> out_n);
  assign out_sum  = {1'b0, osr_cnt} + {1'b0, out_n};

  assign pc_seq  = (pc == cfg.wrap_top) ? cfg.wrap_bottom : pc + 1'b1;
  assign pc_nxt  = jump ? jump_tgt : pc_seq;
  assign exec    = active && (delay_cnt == 5'd0) && !stall;
  assign fifo_rd = exec && pull_pop; // Pop in the same edge the OSR loads

  always_comb begin
    stall       = 1'b0;
    jump        = 1'b0;
    jump_tgt    = d.op2;
    pull_pop    = 1'b0;
    x_nxt       = x_q;
    y_nxt       = y_q;
    osr_nxt     = osr;
    osr_cnt_nxt = osr_cnt;
    pins_nxt    = pins_out;
    dirs_nxt    = pin_dirs;
    case (d.op)
      pio_pkg::OP_JMP: begin
        case (d.op1)
          3'd0: jump = 1'b1;
          3'd1: jump = (x_q == '0);
          3'd2: begin
            jump  = (x_q != '0);
            x_nxt = x_q - 1'b1; // Post-decrement either way
          end
          3'd3: jump = (y_q == '0);
          3'd4: begin
            jump  = (y_q != '0);
            y_nxt = y_q - 1'b1;
          end
          3'd5: jump = (x_q != y_q);
          3'd6: jump = gpio_in[cfg.jmp_pin];
          default: jump = (osr_cnt < pio_pkg::OSR_EMPTY);
        endcase
      end
      pio_pkg::OP_WAIT: stall = (gpio_in[cfg.gpio_sel] != d.op1[2]);
      pio_pkg::OP_OUT: begin
        osr_nxt     = osr_shr; // Right shift only
        osr_cnt_nxt = (out_sum > {1'b0, pio_pkg::OSR_EMPTY}) ? pio_pkg::OSR_EMPTY
                                                              : out_sum[5:0];
        case (d.op1)
          3'd0: pins_nxt = merge_pins(pins_out, out_val, cfg.out_base, cfg.out_count);
          3'd1: x_nxt = out_val;
          3'd2: y_nxt = out_val;
          3'd4: dirs_nxt = merge_pins(pin_dirs, out_val, cfg.out_base, cfg.out_count);
          3'd5: begin
            jump     = 1'b1;
            jump_tgt = out_val[4:0];
          end
          default: ; // Null discards
        endcase
      end
      pio_pkg::OP_PULL: begin
        if (d.op1[2]) begin
          if (!fifo_empty) begin
            osr_nxt     = fifo_data;
            osr_cnt_nxt = '0;
            pull_pop    = 1'b1;
          end else if (d.op1[0]) begin
            stall = 1'b1; // Blocking pull waits for data
          end else begin
            osr_nxt     = x_q;
            osr_cnt_nxt = '0;
          end
        end
      end
      pio_pkg::OP_SET: begin
        case (d.op1)
          3'd0: pins_nxt = merge_pins(pins_out, {27'b0, d.op2}, cfg.set_base,
                                      {3'b0, cfg.set_count});
          3'd1: x_nxt = {27'b0, d.op2};
          3'd2: y_nxt = {27'b0, d.op2};
          3'd4: dirs_nxt = merge_pins(pin_dirs, {27'b0, d.op2}, cfg.set_base,
                                      {3'b0, cfg.set_count});
          default: ;
        endcase
      end
      pio_pkg::OP_IN, pio_pkg::OP_MOV, pio_pkg::OP_IRQ: ; // Executed as no-ops
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= '0;
      x_q       <= '0;
      y_q       <= '0;
      osr_cnt   <= pio_pkg::OSR_EMPTY;
      delay_cnt <= '0;
      pins_out  <= '0;
      pin_dirs  <= '0;
    end else if (active) begin
      if (delay_cnt != 5'd0) begin
        delay_cnt <= delay_cnt - 1'b1; // PC holds during delay
      end else if (!stall) begin
        pc        <= pc_nxt;
        x_q       <= x_nxt;
        y_q       <= y_nxt;
        osr_cnt   <= osr_cnt_nxt;
        pins_out  <= pins_nxt;
        pin_dirs  <= dirs_nxt;
        delay_cnt <= d.delay;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exec) begin
      osr <= osr_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/pio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_top (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             en,
  input  wire pio_pkg::sm_cfg_t cfg,
  input  wire logic             prog_we,
  input  wire pio_pkg::pc_t     prog_addr,
  input  wire pio_pkg::instr_t  prog_data,
  input  wire logic             tx_wr,
  input  wire pio_pkg::word_t   tx_data,
  output logic                  tx_full,
  input  wire pio_pkg::word_t   gpio_in,
  output pio_pkg::word_t        pins_out,
  output pio_pkg::word_t        pin_dirs,
  output pio_pkg::pc_t          pc
);

  logic            tick;
  pio_pkg::instr_t instr;
  pio_pkg::word_t  fifo_data;
  logic            fifo_empty;
  logic            fifo_rd;

  pio_clk_div u_div (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .div   (cfg.div),
    .tick  (tick)
  );

  pio_instr_mem u_imem (
    .clk   (clk),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (pc),
    .rdata (instr)
  );

  pio_tx_fifo u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (tx_wr),
    .wdata (tx_data),
    .rd    (fifo_rd),
    .rdata (fifo_data),
    .empty (fifo_empty),
    .full  (tx_full)
  );

  pio_sm u_sm (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .tick       (tick),
    .cfg        (cfg),
    .instr      (instr),
    .gpio_in    (gpio_in),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .fifo_rd    (fifo_rd),
    .pc         (pc),
    .pins_out   (pins_out),
    .pin_dirs   (pin_dirs)
  );

endmodule

`default_nettype wire

// ==== source/pio_tx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_tx_fifo (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           wr,
  input  wire pio_pkg::word_t wdata,
  input  wire logic           rd,
  output pio_pkg::word_t      rdata,
  output logic                empty,
  output logic                full
);

  pio_pkg::word_t                 mem [pio_pkg::FIFO_DEPTH];
  logic [pio_pkg::FIFO_AW-1:0]    wr_ptr;
  logic [pio_pkg::FIFO_AW-1:0]    rd_ptr;
  logic [pio_pkg::FIFO_AW:0]      count;
  logic                           wr_ok;
  logic                           rd_ok;

  assign wr_ok = wr && !full; // Writes while full are dropped
  assign rd_ok = rd && !empty;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (int'(wr_ptr) == pio_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (int'(rd_ptr) == pio_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign rdata = mem[rd_ptr]; // Show-ahead head word
  assign empty = (count == '0);
  assign full  = (count == pio_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

// ==== verif/pio_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_chk (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      wr,
  input wire logic                      rd,
  input wire logic                      empty,
  input wire logic                      full,
  input wire logic [pio_pkg::FIFO_AW:0] count
);

  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    int'(count) <= pio_pkg::FIFO_DEPTH)
    else $error("FIFO count above depth");

  a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rd |-> !empty)
    else $error("FIFO read while empty");

  // Dropped write must not move the count
  a_full_drop: assert property (@(posedge clk) disable iff (!rst_n)
    wr && full && !rd |=> count == $past(count))
    else $error("FIFO count changed on write while full");

  a_reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> empty)
    else $error("FIFO not empty after reset");

endmodule

bind pio_tx_fifo pio_chk u_chk (
  .clk   (clk),
  .rst_n (rst_n),
  .wr    (wr),
  .rd    (rd),
  .empty (empty),
  .full  (full),
  .count (count)
);

`default_nettype wire

// ==== verif/pio_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_tb;

  // Cycles per test for reset, setup and running with slack for stalls
  localparam int TEST_CYCLES = 60 + 160 + 220 + 260 + 200 + 100;
  localparam int MAX_CYCLES  = TEST_CYCLES + 400;

  logic             clk;
  logic             rst_n;
  logic             en;
  pio_pkg::sm_cfg_t cfg;
  logic             prog_we;
  pio_pkg::pc_t     prog_addr;
  pio_pkg::instr_t  prog_data;
  logic             tx_wr;
  pio_pkg::word_t   tx_data;
  logic             tx_full;
  pio_pkg::word_t   gpio_in;
  pio_pkg::word_t   pins_out;
  pio_pkg::word_t   pin_dirs;
  pio_pkg::pc_t     pc;

  pio_pkg::instr_t  prog [pio_pkg::IMEM_DEPTH];
  integer           seed;
  int               cycles = 0;
  int               errors;
  int               tests_passed;
  int               tests_failed;

  pio_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .cfg       (cfg),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .tx_wr     (tx_wr),
    .tx_data   (tx_data),
    .tx_full   (tx_full),
    .gpio_in   (gpio_in),
    .pins_out  (pins_out),
    .pin_dirs  (pin_dirs),
    .pc        (pc)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: simulation ran past %0d cycles without finishing", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // Low n_bits of val rotated onto count pins from base
  function automatic pio_pkg::word_t expect_pins(input pio_pkg::word_t cur,
                                                 input pio_pkg::word_t val,
                                                 input int n_bits,
                                                 input pio_pkg::pin_idx_t base,
                                                 input int count);
    pio_pkg::word_t src;
    pio_pkg::word_t mask;
    pio_pkg::word_t rmask;
    pio_pkg::word_t rval;
    src   = (n_bits >= 32) ? val : (val & ((32'd1 << n_bits) - 32'd1));
    mask  = (count >= 32) ? 32'hffff_ffff : ((32'd1 << count) - 32'd1);
    rmask = (mask << base) | (mask >> (32 - int'(base))); // Shift by 32 gives 0
    rval  = ((src & mask) << base) | ((src & mask) >> (32 - int'(base)));
    return (cur & ~rmask) | (rval & rmask);
  endfunction

  function automatic pio_pkg::instr_t encode(input pio_pkg::op_e op, input logic [4:0] delay,
                                             input logic [2:0] op1, input logic [4:0] op2);
    return {op, delay, op1, op2};
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check(input pio_pkg::word_t got, input pio_pkg::word_t exp,
                       input string what);
    if (got !== exp) begin
      $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic reset_dut();
    en      = 1'b0;
    tx_wr   = 1'b0;
    prog_we = 1'b0;
    gpio_in = '0;
    rst_n   = 1'b0;
    repeat (5) next_cycle();
    rst_n   = 1'b1;
  endtask

  task automatic default_cfg();
    cfg             = '0;
    cfg.div         = 16'd1;
    cfg.wrap_bottom = 5'd0;
    cfg.wrap_top    = 5'd31;
    cfg.out_count   = 6'd32;
    cfg.set_count   = 3'd5;
  endtask

  task automatic load_program(input int n);
    for (int i = 0; i < n; i++) begin
      prog_we   = 1'b1;
      prog_addr = pio_pkg::pc_t'(i);
      prog_data = prog[i];
      next_cycle();
    end
    prog_we = 1'b0;
  endtask

  task automatic push_word(input pio_pkg::word_t w);
    tx_wr   = 1'b1;
    tx_data = w;
    next_cycle();
    tx_wr   = 1'b0;
  endtask

  task automatic wait_pc(input pio_pkg::pc_t target, input int max_cycles);
    int n;
    n = 0;
    while (pc !== target && n < max_cycles) begin
      next_cycle();
      n++;
    end
    if (pc !== target) begin
      $display("pc did not reach %0d within %0d cycles, stuck at %0d", target, max_cycles, pc);
      errors++;
    end
  endtask

  // Pull and OUT to pins followed by a two-phase GPIO acknowledge
  task automatic build_stream_program(input logic [4:0] n_bits);
    prog[0] = encode(pio_pkg::OP_PULL, 5'd0, 3'b101, 5'd0); // Blocking
    prog[1] = encode(pio_pkg::OP_OUT, 5'd0, 3'd0, n_bits);
    prog[2] = encode(pio_pkg::OP_WAIT, 5'd0, 3'b100, 5'd0); // Ack high
    prog[3] = encode(pio_pkg::OP_WAIT, 5'd0, 3'b000, 5'd0);
    prog[4] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd0);
    load_program(5);
  endtask

  task automatic ack_word(input pio_pkg::word_t exp, input string what);
    wait_pc(5'd2, 40);
    check(pins_out, exp, what);
    gpio_in[cfg.gpio_sel] = 1'b1;
    wait_pc(5'd3, 20);
    gpio_in[cfg.gpio_sel] = 1'b0;
  endtask

  task automatic clocks_to_change(output int n);
    pio_pkg::word_t prev;
    prev = pins_out;
    n    = 0;
    while (pins_out === prev && n < 64) begin
      next_cycle();
      n++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    if (errors == err_start) begin
      $display("Test %0d %s: PASS", num, name);
      tests_passed++;
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", num, name, errors - err_start);
      tests_failed++;
    end
  endtask

  initial begin
    pio_pkg::word_t words [7];
    pio_pkg::word_t expected;
    logic [4:0]     v_a;
    logic [4:0]     v_b;
    int             n;
    int             bit_val;
    int             err_start;
    seed         = 70;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    en           = 1'b0;
    cfg          = '0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    tx_wr        = 1'b0;
    tx_data      = '0;
    gpio_in      = '0;

    // SET to pins and pindirs
    err_start = errors;
    reset_dut();
    default_cfg();
    check(pins_out, '0, "pins_out after reset");
    check(pin_dirs, '0, "pin_dirs after reset");
    check(pio_pkg::word_t'(pc), '0, "pc after reset");
    cfg.set_base  = pio_pkg::pin_idx_t'(rand_below(32));
    cfg.set_count = 3'(1 + rand_below(5));
    v_a = 5'(rand_below(32));
    v_b = 5'(rand_below(32));
    prog[0] = encode(pio_pkg::OP_SET, 5'd0, 3'd4, v_a);
    prog[1] = encode(pio_pkg::OP_SET, 5'd0, 3'd0, v_b);
    prog[2] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd2);
    load_program(3);
    en = 1'b1;
    wait_pc(5'd2, 20);
    check(pin_dirs, expect_pins('0, 32'(v_a), 5, cfg.set_base, int'(cfg.set_count)),
          "pin_dirs after SET");
    check(pins_out, expect_pins('0, 32'(v_b), 5, cfg.set_base, int'(cfg.set_count)),
          "pins_out after SET");
    report_test(1, "set pins and dirs", err_start);

    // PULL and OUT stream
    err_start = errors;
    reset_dut();
    default_cfg();
    cfg.out_base  = pio_pkg::pin_idx_t'(rand_below(32));
    cfg.out_count = 6'(1 + rand_below(32));
    cfg.gpio_sel  = pio_pkg::pin_idx_t'(rand_below(32));
    for (int i = 0; i < 4; i++) begin
      words[i] = $random(seed);
      push_word(words[i]);
    end
    build_stream_program(cfg.out_count[4:0]); // 32 encodes as 0
    en = 1'b1;
    expected = '0;
    for (int i = 0; i < 4; i++) begin
      expected = expect_pins(expected, words[i], int'(cfg.out_count), cfg.out_base,
                             int'(cfg.out_count));
      ack_word(expected, "pins_out after OUT");
    end
    report_test(2, "pull and out", err_start);

    // FIFO back-pressure
    err_start = errors;
    reset_dut();
    default_cfg();
    cfg.gpio_sel = pio_pkg::pin_idx_t'(rand_below(32));
    for (int i = 0; i < 7; i++) begin
      words[i] = $random(seed);
    end
    for (int i = 0; i < 6; i++) begin
      push_word(words[i]);
      check(32'(tx_full), (i >= 3) ? 32'd1 : 32'd0, "tx_full while filling");
    end
    build_stream_program(5'd0);
    en = 1'b1;
    for (int i = 0; i < 4; i++) begin
      ack_word(words[i], "drained word");
    end
    wait_pc(5'd0, 20);
    check(32'(tx_full), 32'd0, "tx_full after drain");
    repeat (10) begin
      next_cycle();
      check(pio_pkg::word_t'(pc), '0, "pc held by blocking PULL");
    end
    push_word(words[6]);
    ack_word(words[6], "word pushed after stall");
    report_test(3, "fifo back-pressure", err_start);

    // Countdown loop on X
    err_start = errors;
    reset_dut();
    default_cfg();
    n = 1 + rand_below(15);
    prog[0] = encode(pio_pkg::OP_SET, 5'd0, 3'd1, 5'(n));
    prog[1] = encode(pio_pkg::OP_JMP, 5'd0, 3'd2, 5'd1); // X-- to itself
    prog[2] = encode(pio_pkg::OP_SET, 5'd0, 3'd0, 5'd1);
    prog[3] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd3);
    load_program(4);
    en = 1'b1;
    wait_pc(5'd3, n + 10);
    check(pins_out, expect_pins('0, 32'd1, 5, 5'd0, 5), "pins_out after X loop");
    repeat (4) next_cycle();
    check(pio_pkg::word_t'(pc), 32'd3, "pc after X loop");

    // Jump on pin
    reset_dut();
    default_cfg();
    cfg.jmp_pin = pio_pkg::pin_idx_t'(rand_below(32));
    bit_val = rand_below(2);
    gpio_in[cfg.jmp_pin] = bit_val[0];
    prog[0] = encode(pio_pkg::OP_JMP, 5'd0, 3'd6, 5'd3);
    prog[1] = encode(pio_pkg::OP_SET, 5'd0, 3'd0, 5'd2);
    prog[2] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd2);
    prog[3] = encode(pio_pkg::OP_SET, 5'd0, 3'd0, 5'd5);
    prog[4] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd4);
    load_program(5);
    en = 1'b1;
    wait_pc(bit_val ? 5'd4 : 5'd2, 10);
    check(pins_out, bit_val ? 32'd5 : 32'd2, "pins_out after jump on pin");

    // Jump on X not equal to Y
    reset_dut();
    default_cfg();
    v_a = 5'(rand_below(32));
    v_b = rand_below(2) ? v_a : 5'(rand_below(32));
    prog[0] = encode(pio_pkg::OP_SET, 5'd0, 3'd1, v_a);
    prog[1] = encode(pio_pkg::OP_SET, 5'd0, 3'd2, v_b);
    prog[2] = encode(pio_pkg::OP_JMP, 5'd0, 3'd5, 5'd5);
    prog[3] = encode(pio_pkg::OP_SET, 5'd0, 3'd0, 5'd2);
    prog[4] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd4);
    prog[5] = encode(pio_pkg::OP_SET, 5'd0, 3'd0, 5'd5);
    prog[6] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd6);
    load_program(7);
    en = 1'b1;
    wait_pc((v_a != v_b) ? 5'd6 : 5'd4, 12);
    check(pins_out, (v_a != v_b) ? 32'd5 : 32'd2, "pins_out after X != Y jump");
    report_test(4, "jumps", err_start);

    // Divider and delay
    err_start = errors;
    reset_dut();
    default_cfg();
    cfg.div       = 16'd4;
    cfg.wrap_top  = 5'd1; // Two SETs alternate through wrap
    cfg.set_count = 3'd1;
    prog[0] = encode(pio_pkg::OP_SET, 5'd3, 3'd0, 5'd1);
    prog[1] = encode(pio_pkg::OP_SET, 5'd3, 3'd0, 5'd0);
    load_program(2);
    en = 1'b1;
    clocks_to_change(n);
    if (n >= 64) begin
      $display("pins_out never changed after enabling the divided program");
      errors++;
    end
    for (int k = 0; k < 5; k++) begin
      clocks_to_change(n);
      check(32'(n), 32'((1 + 3) * int'(cfg.div)), "clocks between pin changes");
    end
    report_test(5, "divider and delay", err_start);

    // WAIT on GPIO
    err_start = errors;
    reset_dut();
    default_cfg();
    cfg.div      = 16'd3;
    cfg.gpio_sel = pio_pkg::pin_idx_t'(rand_below(32));
    gpio_in      = $random(seed);
    gpio_in[cfg.gpio_sel] = 1'b0;
    prog[0] = encode(pio_pkg::OP_WAIT, 5'd0, 3'b100, 5'd0);
    prog[1] = encode(pio_pkg::OP_SET, 5'd0, 3'd0, 5'd3);
    prog[2] = encode(pio_pkg::OP_JMP, 5'd0, 3'd0, 5'd2);
    load_program(3);
    en = 1'b1;
    repeat (10) begin
      next_cycle();
      check(pio_pkg::word_t'(pc), '0, "pc held by WAIT");
    end
    gpio_in[cfg.gpio_sel] = 1'b1;
    n = 0;
    while (pc === 5'd0 && n < 20) begin
      next_cycle();
      n++;
    end
    check(32'(n > int'(cfg.div)), 32'd0, "WAIT release slower than one tick");
    wait_pc(5'd2, 10);
    check(pins_out, expect_pins('0, 32'd3, 5, 5'd0, 5), "pins_out after WAIT");
    report_test(6, "wait on gpio", err_start);

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
